//--- src/ibuf_params.svh
`ifndef IBUF_PARAMS_SVH
`define IBUF_PARAMS_SVH

// bytes per line
`define IBUF_LINE_BYTES 16

// line width in bits
`define IBUF_LINE_W 128

// line slots in the ring, even lines in 0/2, odd lines in 1/3
`define IBUF_SLOTS 4

// byte address width on the fetch side and the bus
`define IBUF_ADDR_W 32

// pointer width, covers the 64 ring bytes
`define IBUF_BIP_W 6

`endif

//--- src/ibuf_pkg.sv
`default_nettype none

`include "ibuf_params.svh"

package ibuf_pkg;

    // one instruction line, byte 0 in bits 7:0
    typedef logic [`IBUF_LINE_W-1:0] line_t;

    // slot number, same as line address modulo slot count
    typedef logic [$clog2(`IBUF_SLOTS)-1:0] slot_idx_t;

    // byte offset into the ring
    typedef logic [`IBUF_BIP_W-1:0] bip_t;

    // line address, byte address with the line offset dropped
    typedef logic [`IBUF_ADDR_W-$clog2(`IBUF_LINE_BYTES)-1:0] line_addr_t;

    // how many lines the next refill brings in
    typedef enum logic [1:0] {
        FILL_NONE = 2'd0,
        FILL_ONE  = 2'd1,
        FILL_TWO  = 2'd2
    } fill_mode_t;

endpackage

`default_nettype wire

//--- src/fill_state.sv
`default_nettype none

`include "ibuf_params.svh"

module fill_state (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   redirect,
    input  logic                   fill_busy,
    input  ibuf_pkg::slot_idx_t    fetch_slot,
    input  logic [`IBUF_SLOTS-1:0] slot_valid,
    output ibuf_pkg::fill_mode_t   fill_mode
);

    ibuf_pkg::slot_idx_t  next_slot;
    logic                 first_free;
    logic                 next_free;
    ibuf_pkg::fill_mode_t mode_next;

    // the fetch slot and the one after it always differ in parity, so a
    // two line fill is one even and one odd line, in either order
    assign next_slot = fetch_slot + 1'b1;

    assign first_free = ~slot_valid[fetch_slot];
    assign next_free  = ~slot_valid[next_slot];

    always_comb begin
        if (first_free && next_free) begin
            mode_next = ibuf_pkg::FILL_TWO;
        end else if (first_free) begin
            mode_next = ibuf_pkg::FILL_ONE; // next slot still holds a line
        end else begin
            mode_next = ibuf_pkg::FILL_NONE;
        end
    end

    // decision is frozen while the read engine works through it
    always_ff @(posedge clk) begin
        if (rst) begin
            fill_mode <= ibuf_pkg::FILL_NONE;
        end else if (redirect) begin
            fill_mode <= ibuf_pkg::FILL_TWO; // buffer is emptied at the same edge
        end else if (!fill_busy) begin
            fill_mode <= mode_next;
        end
    end

endmodule

`default_nettype wire

//--- src/line_fetch_wb.sv
`default_nettype none

`include "ibuf_params.svh"

module line_fetch_wb (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    redirect,
    input  logic [`IBUF_ADDR_W-1:0] redirect_addr,
    input  ibuf_pkg::fill_mode_t    fill_mode,
    output logic                    fill_busy,
    output ibuf_pkg::slot_idx_t     fetch_slot,

    // wishbone classic master, read only
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic [`IBUF_ADDR_W-1:0] wb_adr,
    input  logic [`IBUF_LINE_W-1:0] wb_dat_i,
    input  logic                    wb_ack,

    output logic                    line_wr,
    output ibuf_pkg::slot_idx_t     line_wr_slot,
    output ibuf_pkg::line_t         line_wr_data
);

    localparam int OFF_W = $clog2(`IBUF_LINE_BYTES);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RD1,
        ST_RD2
    } state_t;

    state_t               state;
    ibuf_pkg::line_addr_t fetch_line;
    logic                 bus_req;
    logic                 acked;

    assign wb_cyc = bus_req;
    assign wb_stb = bus_req; // one transfer per cycle, stb follows cyc
    assign wb_adr = {fetch_line, {OFF_W{1'b0}}};

    assign fetch_slot = fetch_line[$bits(ibuf_pkg::slot_idx_t)-1:0];
    assign fill_busy  = (state != ST_IDLE);
    assign acked      = bus_req & wb_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            bus_req    <= 1'b0;
            fetch_line <= '0;
            line_wr    <= 1'b0;
        end else if (redirect) begin
            // abandon the cycle in flight, an ack right now is dropped
            state      <= ST_IDLE;
            bus_req    <= 1'b0;
            fetch_line <= redirect_addr[`IBUF_ADDR_W-1:OFF_W];
            line_wr    <= 1'b0;
        end else begin
            line_wr <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // skip while a write is still landing, the mode is stale then
                    if (fill_mode != ibuf_pkg::FILL_NONE && !line_wr) begin
                        state   <= ST_RD1;
                        bus_req <= 1'b1;
                    end
                end
                ST_RD1: begin
                    if (acked) begin
                        line_wr    <= 1'b1;
                        fetch_line <= fetch_line + 1'b1;
                        if (fill_mode == ibuf_pkg::FILL_TWO) begin
                            state <= ST_RD2; // next address goes out back to back
                        end else begin
                            state   <= ST_IDLE;
                            bus_req <= 1'b0;
                        end
                    end
                end
                ST_RD2: begin
                    if (acked) begin
                        line_wr    <= 1'b1;
                        fetch_line <= fetch_line + 1'b1;
                        state      <= ST_IDLE;
                        bus_req    <= 1'b0;
                    end
                end
                default: begin
                    state   <= ST_IDLE;
                    bus_req <= 1'b0;
                end
            endcase
        end
    end

    // returned line and its slot, handed to the latch the cycle after ack
    always_ff @(posedge clk) begin
        if (acked) begin
            line_wr_data <= wb_dat_i;
            line_wr_slot <= fetch_slot;
        end
    end

endmodule

`default_nettype wire

//--- src/ibuf_pointer.sv
`default_nettype none

`include "ibuf_params.svh"

module ibuf_pointer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      redirect,
    input  logic [`IBUF_ADDR_W-1:0]   redirect_addr,
    input  logic [4:0]                advance,
    input  logic [`IBUF_SLOTS-1:0]    slot_valid,
    input  logic [2*`IBUF_LINE_W-1:0] pair_bytes,
    output logic [`IBUF_LINE_W-1:0]   window,
    output logic                      window_valid,
    output logic                      release_en,
    output ibuf_pkg::slot_idx_t       release_slot,
    output ibuf_pkg::bip_t            bip
);

    localparam int OFF_W = $clog2(`IBUF_LINE_BYTES);

    ibuf_pkg::slot_idx_t cur_slot;
    ibuf_pkg::slot_idx_t nxt_slot;
    ibuf_pkg::slot_idx_t new_slot;
    ibuf_pkg::bip_t      bip_next;
    logic [OFF_W-1:0]    line_off;
    logic                take;

    assign cur_slot = bip[`IBUF_BIP_W-1:OFF_W];
    assign nxt_slot = cur_slot + 1'b1;
    assign line_off = bip[OFF_W-1:0];

    // a full 16 byte window may reach into the following slot
    assign window_valid = slot_valid[cur_slot] & slot_valid[nxt_slot];

    assign take     = window_valid & ~redirect;
    assign bip_next = bip + ibuf_pkg::bip_t'(advance); // wraps around the ring
    assign new_slot = bip_next[`IBUF_BIP_W-1:OFF_W];

    // at most 16 bytes per advance, so at most one slot is left behind
    assign release_en   = take && (new_slot != cur_slot);
    assign release_slot = cur_slot;

    always_ff @(posedge clk) begin
        if (rst) begin
            bip <= '0;
        end else if (redirect) begin
            bip <= redirect_addr[`IBUF_BIP_W-1:0];
        end else if (take) begin
            bip <= bip_next;
        end
    end

    // byte aligner, pair holds the pointer slot in its low half
    always_comb begin
        for (int i = 0; i < `IBUF_LINE_BYTES; i++) begin
            window[8*i +: 8] = pair_bytes[8*(int'(line_off) + i) +: 8];
        end
    end

endmodule

`default_nettype wire

//--- src/ibuf_latch.sv
`default_nettype none

`include "ibuf_params.svh"

module ibuf_latch (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      redirect,
    input  logic                      line_wr,
    input  ibuf_pkg::slot_idx_t       line_wr_slot,
    input  ibuf_pkg::line_t           line_wr_data,
    input  logic                      release_en,
    input  ibuf_pkg::slot_idx_t       release_slot,
    input  ibuf_pkg::bip_t            bip,
    output logic [`IBUF_SLOTS-1:0]    slot_valid,
    output logic [2*`IBUF_LINE_W-1:0] pair_bytes
);

    localparam int OFF_W = $clog2(`IBUF_LINE_BYTES);

    ibuf_pkg::line_t       slot_line [`IBUF_SLOTS];
    logic [`IBUF_SLOTS-1:0] ld;
    logic [`IBUF_SLOTS-1:0] clr;
    ibuf_pkg::slot_idx_t   cur_slot;
    ibuf_pkg::slot_idx_t   nxt_slot;

    // load decode, one slot per written line
    always_comb begin
        ld = '0;
        if (line_wr) begin
            ld[line_wr_slot] = 1'b1;
        end
    end

    always_comb begin
        clr = '0;
        if (release_en) begin
            clr[release_slot] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            slot_valid <= '0; // flush drops a line landing this cycle too
        end else begin
            for (int i = 0; i < `IBUF_SLOTS; i++) begin
                if (ld[i]) begin
                    slot_valid[i] <= 1'b1;
                end else if (clr[i]) begin
                    slot_valid[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `IBUF_SLOTS; i++) begin
            if (ld[i]) begin
                slot_line[i] <= line_wr_data;
            end
        end
    end

    assign cur_slot = bip[`IBUF_BIP_W-1:OFF_W];
    assign nxt_slot = cur_slot + 1'b1; // wraps from slot 3 back to 0

    // current slot in the low half, the one after it above
    assign pair_bytes = {slot_line[nxt_slot], slot_line[cur_slot]};

endmodule

`default_nettype wire

//--- src/ibuf_top.sv
`default_nettype none

`include "ibuf_params.svh"

module ibuf_top (
    input  logic                    clk,
    input  logic                    rst,

    // decoder side
    input  logic [4:0]              advance,
    input  logic                    redirect,
    input  logic [`IBUF_ADDR_W-1:0] redirect_addr,
    output logic [`IBUF_LINE_W-1:0] window,
    output logic                    window_valid,

    // instruction memory, wishbone classic
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic [`IBUF_ADDR_W-1:0] wb_adr,
    input  logic [`IBUF_LINE_W-1:0] wb_dat_i,
    input  logic                    wb_ack
);

    ibuf_pkg::fill_mode_t      fill_mode;
    logic                      fill_busy;
    ibuf_pkg::slot_idx_t       fetch_slot;
    logic                      line_wr;
    ibuf_pkg::slot_idx_t       line_wr_slot;
    ibuf_pkg::line_t           line_wr_data;
    logic [`IBUF_SLOTS-1:0]    slot_valid;
    logic [2*`IBUF_LINE_W-1:0] pair_bytes;
    logic                      release_en;
    ibuf_pkg::slot_idx_t       release_slot;
    ibuf_pkg::bip_t            bip;

    fill_state fill_state_i (
        .clk        (clk),
        .rst        (rst),
        .redirect   (redirect),
        .fill_busy  (fill_busy),
        .fetch_slot (fetch_slot),
        .slot_valid (slot_valid),
        .fill_mode  (fill_mode)
    );

    line_fetch_wb line_fetch_wb_i (
        .clk           (clk),
        .rst           (rst),
        .redirect      (redirect),
        .redirect_addr (redirect_addr),
        .fill_mode     (fill_mode),
        .fill_busy     (fill_busy),
        .fetch_slot    (fetch_slot),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_adr        (wb_adr),
        .wb_dat_i      (wb_dat_i),
        .wb_ack        (wb_ack),
        .line_wr       (line_wr),
        .line_wr_slot  (line_wr_slot),
        .line_wr_data  (line_wr_data)
    );

    ibuf_pointer ibuf_pointer_i (
        .clk           (clk),
        .rst           (rst),
        .redirect      (redirect),
        .redirect_addr (redirect_addr),
        .advance       (advance),
        .slot_valid    (slot_valid),
        .pair_bytes    (pair_bytes),
        .window        (window),
        .window_valid  (window_valid),
        .release_en    (release_en),
        .release_slot  (release_slot),
        .bip           (bip)
    );

    ibuf_latch ibuf_latch_i (
        .clk          (clk),
        .rst          (rst),
        .redirect     (redirect),
        .line_wr      (line_wr),
        .line_wr_slot (line_wr_slot),
        .line_wr_data (line_wr_data),
        .release_en   (release_en),
        .release_slot (release_slot),
        .bip          (bip),
        .slot_valid   (slot_valid),
        .pair_bytes   (pair_bytes)
    );

endmodule

`default_nettype wire

//--- verification/imem_wb_model.sv
`default_nettype none

`include "ibuf_params.svh"

module imem_wb_model (
    input  logic                    clk,
    input  logic                    rst,
    input  int unsigned             seed,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic [`IBUF_ADDR_W-1:0] wb_adr,
    output logic [`IBUF_LINE_W-1:0] wb_dat,
    output logic                    wb_ack,
    output logic                    read_stalled
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned rng_state;
    int unsigned wait_now;
    logic        pending;
    logic [1:0]  waits;

    function automatic int unsigned next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state >> 16;
    endfunction

    // memory contents, byte at a is a[7:0] ^ a[15:8]
    function automatic logic [`IBUF_LINE_W-1:0] line_at(input logic [`IBUF_ADDR_W-1:0] adr);
        logic [`IBUF_LINE_W-1:0] line;
        logic [`IBUF_ADDR_W-1:0] a;
        for (int i = 0; i < `IBUF_LINE_BYTES; i++) begin
            a = {adr[`IBUF_ADDR_W-1:4], 4'h0} + i;
            line[8*i +: 8] = a[7:0] ^ a[15:8];
        end
        return line;
    endfunction

    // high when the next cycle is certain to be a wait state as well
    assign read_stalled = wb_cyc & wb_stb & pending & ~wb_ack & (waits != 2'd0);

    always @(posedge clk) begin
        if (rst) begin
            rng_state = seed;
            wb_ack  <= 1'b0;
            wb_dat  <= '0;
            pending <= 1'b0;
            waits   <= 2'd0;
        end else if (wb_ack || !(wb_cyc && wb_stb)) begin
            wb_ack  <= 1'b0; // one ack per request, abandoned requests end here too
            pending <= 1'b0;
        end else begin
            if (!pending) begin
                wait_now = next_rand() % 4; // 0 to 3 wait states
            end else begin
                wait_now = waits;
            end
            pending <= 1'b1;
            if (wait_now == 0) begin
                wb_ack <= 1'b1;
                wb_dat <= line_at(wb_adr);
            end else begin
                waits <= 2'(wait_now - 1);
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/ibuf_tb.sv
`default_nettype none

`include "ibuf_params.svh"

module ibuf_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 100;
    // bytes each test is expected to move through the window, with some slack
    localparam int BUDGET_BYTES   = 16 + 316 + 2 * 56 + 80 + 64;
    localparam int TIMEOUT_CYCLES = 64 * BUDGET_BYTES;

    logic                    clk = 1'b0;
    logic                    rst;
    logic [4:0]              advance;
    logic                    redirect;
    logic [`IBUF_ADDR_W-1:0] redirect_addr;
    logic [`IBUF_LINE_W-1:0] window;
    logic                    window_valid;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic [`IBUF_ADDR_W-1:0] wb_adr;
    logic [`IBUF_LINE_W-1:0] wb_dat;
    logic                    wb_ack;
    logic                    read_stalled;

    int unsigned             rng_state = 26;
    logic [`IBUF_ADDR_W-1:0] exp_addr;
    logic [27:0]             exp_line; // next line the bus should return
    int                      acks;     // lines returned since the last redirect

    ibuf_top ibuf_top_i (
        .clk           (clk),
        .rst           (rst),
        .advance       (advance),
        .redirect      (redirect),
        .redirect_addr (redirect_addr),
        .window        (window),
        .window_valid  (window_valid),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_adr        (wb_adr),
        .wb_dat_i      (wb_dat),
        .wb_ack        (wb_ack)
    );

    imem_wb_model imem_wb_model_i (
        .clk          (clk),
        .rst          (rst),
        .seed         (32'd26),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .wb_dat       (wb_dat),
        .wb_ack       (wb_ack),
        .read_stalled (read_stalled)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int unsigned next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state >> 16;
    endfunction

    function automatic logic [`IBUF_LINE_W-1:0] expected_window(input logic [31:0] addr);
        logic [`IBUF_LINE_W-1:0] w;
        logic [31:0]             a;
        for (int i = 0; i < `IBUF_LINE_BYTES; i++) begin
            a = addr + i;
            w[8*i +: 8] = a[7:0] ^ a[15:8];
        end
        return w;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // bus monitor, every returned line must follow the fetch sequence
    always @(negedge clk) begin
        if (!rst) begin
            check_value("wb_stb", wb_stb, wb_cyc); // stb spans the whole classic cycle
        end
        if (rst) begin
            acks     <= 0;
            exp_line <= '0;
        end else if (redirect) begin
            acks     <= 0; // an ack in this cycle is dropped by the DUT
            exp_line <= redirect_addr[31:4];
        end else if (wb_cyc && wb_stb && wb_ack) begin
            check_value("wb_adr", wb_adr, {exp_line, 4'h0});
            acks     <= acks + 1;
            exp_line <= exp_line + 1'b1;
        end
    end

    task automatic wait_window();
        @(negedge clk);
        while (!window_valid) @(negedge clk);
    endtask

    task automatic take_step(input int n);
        wait_window();
        check_value("window", window, expected_window(exp_addr));
        @(posedge clk);
        advance <= 5'(n);
        @(posedge clk);
        advance <= 5'd0; // taken at this edge, window stayed valid
        exp_addr = exp_addr + n;
    endtask

    task automatic consume_bytes(input int total);
        int done;
        int n;
        done = 0;
        while (done < total) begin
            if (next_rand() % 5 == 0) begin
                n = 16;
            end else begin
                n = int'(next_rand() % 16) + 1;
            end
            take_step(n);
            done = done + n;
        end
    endtask

    task automatic issue_redirect(input logic [31:0] addr);
        @(posedge clk);
        redirect      <= 1'b1;
        redirect_addr <= addr;
        @(posedge clk);
        redirect <= 1'b0;
        exp_addr = addr;
        @(negedge clk);
        check_value("window_valid", window_valid, 1'b0); // flushed, nothing old left
    endtask

    task automatic check_after_reset();
        @(negedge clk);
        check_value("window_valid", window_valid, 1'b0);
        wait_window();
        check_value("window", window, expected_window(32'h0));
    endtask

    task automatic consume_sequential();
        consume_bytes(300);
    endtask

    task automatic redirect_unaligned();
        issue_redirect(32'h0000_1237);
        consume_bytes(40);
        issue_redirect(32'h0000_2a5f); // line offset 15
        consume_bytes(40);
    endtask

    task automatic hold_backpressure();
        logic [`IBUF_LINE_W-1:0] held;
        issue_redirect(32'h0000_0400);
        wait_window();
        check_value("window", window, expected_window(exp_addr));
        held = window;
        repeat (40) begin
            @(negedge clk);
            check_value("window_valid", window_valid, 1'b1);
            check_value("window", window, held);
        end
        if (acks > 4) begin
            check_value("acks_since_redirect", acks, 4);
        end
        check_value("wb_cyc", wb_cyc, 1'b0); // ring full, bus idle
        consume_bytes(64);
    endtask

    task automatic redirect_mid_read();
        issue_redirect(32'h0000_3000);
        @(negedge clk);
        while (!read_stalled) begin
            if (acks >= 4) begin
                issue_redirect(32'h0000_3000); // ring filled before any long wait state
            end
            @(negedge clk);
        end
        // redirect lands in a cycle with cyc high and no ack
        issue_redirect(32'h0000_05a3);
        consume_bytes(48);
    endtask

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: the DUT did not finish the tests within %0d cycles",
                 TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst           = 1'b1;
        advance       = 5'd0;
        redirect      = 1'b0;
        redirect_addr = '0;
        exp_addr      = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        check_after_reset();
        consume_sequential();
        redirect_unaligned();
        hold_backpressure();
        redirect_mid_read();

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+src
src/ibuf_pkg.sv
src/fill_state.sv
src/line_fetch_wb.sv
src/ibuf_pointer.sv
src/ibuf_latch.sv
src/ibuf_top.sv
verification/imem_wb_model.sv
verification/ibuf_tb.sv
